// ==== src.f ====
design/rv_core_pkg.sv
design/mem_bus_if.sv
design/fetch_unit.sv
design/lsu.sv
design/mem_arbiter.sv
design/exec_core.sv
design/rv_mini_top.sv
testbench/tb_clk_gen.sv
testbench/rv_mini_chk.sv
testbench/rv_mini_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rv_mini testbench with Verilator and run it

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module rv_mini_tb -o rv_mini_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv_mini_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi

// ==== testbench/rv_mini_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mini_tb;

    localparam int CYCLES_PER_STEP = 20;
    localparam logic [4:0] X0 = 5'd0;
    localparam logic [4:0] X5 = 5'd5;
    localparam logic [4:0] X6 = 5'd6;
    localparam logic [4:0] X7 = 5'd7;
    localparam logic [4:0] A0 = 5'd10;

    logic        clk;
    logic        rst_i;
    logic [31:0] sram_rdata_i;
    logic        sram_data_valid_i;
    logic [31:0] sram_addr_o;
    logic [31:0] sram_wdata_o;
    logic        sram_ren_o;
    logic        sram_wen_o;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [31:0] retire_instr_o;
    logic [31:0] reg_a0_o;

    logic [31:0] mem [64];
    logic [31:0] step_instr [$];
    logic [31:0] step_pc [$];
    logic [31:0] step_a0 [$];
    int          step_grp [$];
    int          n_steps = 0;
    int          step_idx = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          grp_checks = 0;
    int          grp_errors = 0;
    int          wait_cnt = 0;
    integer      seed = 32'h492e;
    logic [31:0] acc_addr;

    tb_clk_gen #(
        .PERIOD_NS   (100),
        .RESET_CYCLES(3)
    ) tb_clk_gen_inst (
        .clk_o(clk),
        .rst_o(rst_i)
    );

    rv_mini_top #(
        .RESET_PC(32'h0)
    ) rv_mini_top_inst (
        .clk              (clk),
        .rst_i            (rst_i),
        .sram_rdata_i     (sram_rdata_i),
        .sram_data_valid_i(sram_data_valid_i),
        .sram_addr_o      (sram_addr_o),
        .sram_wdata_o     (sram_wdata_o),
        .sram_ren_o       (sram_ren_o),
        .sram_wen_o       (sram_wen_o),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_instr_o   (retire_instr_o),
        .reg_a0_o         (reg_a0_o)
    );

    bind rv_mini_top rv_mini_chk rv_mini_chk_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .ren_i         (sram_ren_o),
        .wen_i         (sram_wen_o),
        .data_valid_i  (sram_data_valid_i),
        .retire_valid_i(retire_valid_o)
    );

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm20);
        rv_core_pkg::instr_u w;
        w.u.imm20  = imm20;
        w.u.rd     = rd;
        w.u.opcode = rv_core_pkg::OPC_LUI;
        return w;
    endfunction

    function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        rv_core_pkg::instr_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        rv_core_pkg::instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = 3'b000;
        w.r.rd     = rd;
        w.r.opcode = rv_core_pkg::OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        rv_core_pkg::instr_u w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = 3'b010;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = rv_core_pkg::OPC_STORE;
        return w;
    endfunction

    // B-type immediate scattered over the S-type fields
    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        rv_core_pkg::instr_u w;
        w.s.imm_hi = {off[12], off[10:5]};
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = f3;
        w.s.imm_lo = {off[4:1], off[11]};
        w.s.opcode = rv_core_pkg::OPC_BRANCH;
        return w;
    endfunction

    function automatic string group_name(input int grp);
        case (grp)
            0:       return "constants";
            1:       return "alu";
            2:       return "load_store";
            default: return "branch";
        endcase
    endfunction

    task automatic add_step(input int grp, input logic [31:0] pc, input logic [31:0] instr,
                            input logic [31:0] a0);
        step_grp.push_back(grp);
        step_pc.push_back(pc);
        step_instr.push_back(instr);
        step_a0.push_back(a0);
        mem[pc[7:2]] = instr;
    endtask

    task automatic build_program();
        // fill with addi x0, x0, <byte address>
        for (int k = 0; k < 64; k++) begin
            mem[k] = itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, X0, X0, 12'(k * 4));
        end
        add_step(0, 32'h00, lui_word(A0, 20'h12345), 32'h1234_5000);
        add_step(0, 32'h04, itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, A0, A0, 12'hff0),
                 32'h1234_4ff0);
        add_step(1, 32'h08, itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, X5, X0, 12'd100),
                 32'h1234_4ff0);
        add_step(1, 32'h0c, itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, X6, X0, 12'd42),
                 32'h1234_4ff0);
        add_step(1, 32'h10, rtype_word(7'h00, A0, X5, X6), 32'h0000_008e);
        add_step(1, 32'h14, rtype_word(7'h20, A0, X5, X6), 32'h0000_003a);
        add_step(1, 32'h18, rtype_word(7'h00, X0, X5, X6), 32'h0000_003a);
        add_step(1, 32'h1c, rtype_word(7'h00, A0, X0, X6), 32'h0000_002a);
        add_step(2, 32'h20, lui_word(X7, 20'hcafeb), 32'h0000_002a);
        add_step(2, 32'h24, itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, X7, X7, 12'h0be),
                 32'h0000_002a);
        add_step(2, 32'h28, sw_word(X7, X0, 12'h080), 32'h0000_002a);
        add_step(2, 32'h2c, itype_word(rv_core_pkg::OPC_LOAD, 3'b010, A0, X0, 12'h080),
                 32'hcafe_b0be);
        add_step(3, 32'h30, branch_word(3'b000, X5, X5, 13'd8), 32'hcafe_b0be);
        add_step(3, 32'h38, branch_word(3'b001, X5, X5, 13'd8), 32'hcafe_b0be);
        add_step(3, 32'h3c, itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, A0, A0, 12'd1),
                 32'hcafe_b0bf);
        add_step(3, 32'h40, branch_word(3'b001, X5, X6, 13'd12), 32'hcafe_b0bf);
        add_step(3, 32'h4c, itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, A0, X0, 12'h123),
                 32'h0000_0123);
        // branch to itself retires again and again
        add_step(3, 32'h50, branch_word(3'b000, X0, X0, 13'd0), 32'h0000_0123);
        add_step(3, 32'h50, branch_word(3'b000, X0, X0, 13'd0), 32'h0000_0123);
        // words behind taken branches would clobber a0
        mem[13] = itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, A0, X0, 12'h7ff);
        mem[17] = itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, A0, X0, 12'h7ff);
        mem[18] = itype_word(rv_core_pkg::OPC_OPIMM, 3'b000, A0, X0, 12'h7ff);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks   = n_checks + 1;
        grp_checks = grp_checks + 1;
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            n_errors   = n_errors + 1;
            grp_errors = grp_errors + 1;
        end
    endtask

    task automatic report_group(input int grp);
        $display("group %s: %0d checks, %0d errors", group_name(grp), grp_checks, grp_errors);
        grp_checks = 0;
        grp_errors = 0;
    endtask

    // sram model with one access at a time and 1 to 4 cycles of latency
    initial begin
        sram_rdata_i      = 32'h0;
        sram_data_valid_i = 1'b0;
        acc_addr          = 32'h0;
        forever begin
            @(posedge clk);
            #1;
            sram_data_valid_i = 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    sram_rdata_i      = mem[acc_addr[7:2]];
                    sram_data_valid_i = 1'b1;
                end
            end
            if (sram_ren_o || sram_wen_o) begin
                acc_addr = sram_addr_o;
                if (sram_wen_o) begin
                    mem[sram_addr_o[7:2]] = sram_wdata_o;
                end
                wait_cnt = 1 + int'($unsigned($random(seed)) % 32'd4);
            end
        end
    end

    initial begin
        @(negedge rst_i);
        repeat (n_steps * CYCLES_PER_STEP) @(posedge clk);
        $display("timeout: retirement %0d of %0d did not arrive within %0d cycles",
                 step_idx, n_steps, n_steps * CYCLES_PER_STEP);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        build_program();
        n_steps = step_instr.size();
        @(negedge rst_i);
        // instruction register holds the nop until the first retirement
        @(negedge clk);
        check_value("retire_instr_o", rv_core_pkg::NOP_INSTR, retire_instr_o);
        for (int i = 0; i < n_steps; i++) begin
            step_idx = i;
            @(negedge clk);
            while (!retire_valid_o) begin
                @(negedge clk);
            end
            check_value("retire_pc_o", step_pc[i], retire_pc_o);
            check_value("retire_instr_o", step_instr[i], retire_instr_o);
            check_value("reg_a0_o", step_a0[i], reg_a0_o);
            if (i == n_steps - 1 || step_grp[i + 1] != step_grp[i]) begin
                report_group(step_grp[i]);
            end
        end
        $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
                 n_checks, n_errors, rv_mini_top_inst.rv_mini_chk_inst.fail_cnt);
        if (n_errors == 0 && rv_mini_top_inst.rv_mini_chk_inst.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rv_mini_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mini_chk (
    input logic clk,
    input logic rst_i,
    input logic ren_i,
    input logic wen_i,
    input logic data_valid_i,
    input logic retire_valid_i
);

    int   fail_cnt = 0;
    logic outstanding_q;
    logic in_reset_q;

    always_ff @(posedge clk) begin
        in_reset_q <= rst_i;
        if (rst_i) begin
            outstanding_q <= 1'b0;
        end else if (ren_i || wen_i) begin
            outstanding_q <= 1'b1;
        end else if (data_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    strobe_exclusive: assert property (@(posedge clk) disable iff (rst_i)
        !(ren_i && wen_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("sram read and write strobes high in the same cycle");
    end

    // one access at a time on the external port
    single_outstanding: assert property (@(posedge clk) disable iff (rst_i)
        (ren_i || wen_i) |-> !outstanding_q)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("new sram strobe while an access is still outstanding");
    end

    quiet_in_reset: assert property (@(posedge clk)
        (rst_i && in_reset_q) |-> !retire_valid_i)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("retire_valid_o high during reset");
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released 1 ns after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== design/rv_mini_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mini_top #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic [31:0] sram_rdata_i,
    input  logic        sram_data_valid_i,
    output logic [31:0] sram_addr_o,
    output logic [31:0] sram_wdata_o,
    output logic        sram_ren_o,
    output logic        sram_wen_o,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic [31:0] retire_instr_o,
    output logic [31:0] reg_a0_o
);

    // fetch to execute
    logic        take;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;

    // execute to lsu
    logic        ls_start;
    logic        ls_we;
    logic [31:0] ls_addr;
    logic [31:0] ls_wdata;
    logic        ls_done;
    logic [31:0] ls_rdata;

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .take_i       (take),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .instr_valid_o(instr_valid),
        .instr_o      (instr),
        .pc_o         (pc),
        .bus          (fetch_bus)
    );

    exec_core exec_core_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .take_o        (take),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ls_start_o    (ls_start),
        .ls_we_o       (ls_we),
        .ls_addr_o     (ls_addr),
        .ls_wdata_o    (ls_wdata),
        .ls_done_i     (ls_done),
        .ls_rdata_i    (ls_rdata),
        .retire_valid_o(retire_valid_o),
        .retire_pc_o   (retire_pc_o),
        .retire_instr_o(retire_instr_o),
        .reg_a0_o      (reg_a0_o)
    );

    lsu lsu_inst (
        .clk    (clk),
        .rst_i  (rst_i),
        .start_i(ls_start),
        .we_i   (ls_we),
        .addr_i (ls_addr),
        .wdata_i(ls_wdata),
        .done_o (ls_done),
        .rdata_o(ls_rdata),
        .bus    (data_bus)
    );

    mem_arbiter mem_arbiter_inst (
        .clk              (clk),
        .rst_i            (rst_i),
        .fetch_bus        (fetch_bus),
        .data_bus         (data_bus),
        .sram_rdata_i     (sram_rdata_i),
        .sram_data_valid_i(sram_data_valid_i),
        .sram_addr_o      (sram_addr_o),
        .sram_wdata_o     (sram_wdata_o),
        .sram_ren_o       (sram_ren_o),
        .sram_wen_o       (sram_wen_o)
    );

endmodule

`default_nettype wire

// ==== design/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    output logic        take_o,
    output logic        redirect_o,
    output logic [31:0] redirect_pc_o,
    output logic        ls_start_o,
    output logic        ls_we_o,
    output logic [31:0] ls_addr_o,
    output logic [31:0] ls_wdata_o,
    input  logic        ls_done_i,
    input  logic [31:0] ls_rdata_i,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic [31:0] retire_instr_o,
    output logic [31:0] reg_a0_o
);

    localparam int W = rv_core_pkg::XLEN;

    logic [W-1:0]        regs [32];
    logic                wait_q;
    logic                retire_q;
    logic [31:0]         ir_q;
    logic [31:0]         pc_q;
    rv_core_pkg::instr_u cur;
    rv_core_pkg::alu_op_e alu_op;
    logic [W-1:0]        rs1_val;
    logic [W-1:0]        rs2_val;
    logic [W-1:0]        op_b;
    logic [W-1:0]        alu_res;
    logic [W-1:0]        imm_i;
    logic [W-1:0]        imm_s;
    logic [W-1:0]        imm_u;
    logic [W-1:0]        imm_b;
    logic                is_load;
    logic                is_store;
    logic                is_branch;
    logic                wr_rd;
    logic                br_taken;
    logic                wb_en;
    logic [W-1:0]        wb_data;

    // while a load is outstanding, decode the held instruction
    assign cur = wait_q ? ir_q : instr_i;

    assign imm_i = {{20{cur.i.imm[11]}}, cur.i.imm};
    assign imm_s = {{20{cur.s.imm_hi[6]}}, cur.s.imm_hi, cur.s.imm_lo};
    assign imm_u = {cur.u.imm20, 12'h000};
    assign imm_b = {{20{cur.s.imm_hi[6]}}, cur.s.imm_lo[0], cur.s.imm_hi[5:0],
                    cur.s.imm_lo[4:1], 1'b0};

    assign rs1_val = regs[cur.r.rs1];
    assign rs2_val = regs[cur.r.rs2];

    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        wr_rd     = 1'b0;
        alu_op    = rv_core_pkg::ALU_ADD;
        op_b      = imm_i;
        case (cur.r.opcode)
            rv_core_pkg::OPC_LUI: begin
                wr_rd  = 1'b1;
                alu_op = rv_core_pkg::ALU_PASSB;
                op_b   = imm_u;
            end
            rv_core_pkg::OPC_OPIMM: begin
                wr_rd = (cur.i.funct3 == 3'b000);
            end
            rv_core_pkg::OPC_OP: begin
                wr_rd  = (cur.r.funct3 == 3'b000) &&
                         (cur.r.funct7 == 7'h00 || cur.r.funct7 == 7'h20);
                alu_op = cur.r.funct7[5] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                op_b   = rs2_val;
            end
            rv_core_pkg::OPC_LOAD: begin
                is_load = (cur.i.funct3 == 3'b010);
            end
            rv_core_pkg::OPC_STORE: begin
                is_store = (cur.s.funct3 == 3'b010);
                op_b     = imm_s;
            end
            rv_core_pkg::OPC_BRANCH: begin
                // beq and bne only
                is_branch = (cur.s.funct3[2:1] == 2'b00);
                alu_op    = rv_core_pkg::ALU_SUB;
                op_b      = rs2_val;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_ADD:   alu_res = rs1_val + op_b;
            rv_core_pkg::ALU_SUB:   alu_res = rs1_val - op_b;
            default:                alu_res = op_b;
        endcase
    end

    assign br_taken = is_branch && ((alu_res == '0) ^ cur.s.funct3[0]);

    assign take_o        = instr_valid_i && !wait_q;
    assign redirect_o    = take_o && br_taken;
    assign redirect_pc_o = pc_i + imm_b;

    assign ls_start_o = take_o && (is_load || is_store);
    assign ls_we_o    = is_store;
    assign ls_addr_o  = alu_res;
    assign ls_wdata_o = rs2_val;

    assign wb_en   = (take_o && wr_rd) || (wait_q && ls_done_i && is_load);
    assign wb_data = wait_q ? ls_rdata_i : alu_res;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_en && cur.r.rd != 5'd0) begin
            regs[cur.r.rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wait_q   <= 1'b0;
            retire_q <= 1'b0;
            ir_q     <= rv_core_pkg::NOP_INSTR;
        end else begin
            retire_q <= (take_o && !ls_start_o) || (wait_q && ls_done_i);
            if (ls_start_o) begin
                wait_q <= 1'b1;
            end else if (ls_done_i) begin
                wait_q <= 1'b0;
            end
            if (take_o) begin
                ir_q <= instr_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_o) begin
            pc_q <= pc_i;
        end
    end

    assign retire_valid_o = retire_q;
    assign retire_pc_o    = pc_q;
    assign retire_instr_o = ir_q;
    assign reg_a0_o       = regs[10];

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic        clk,
    input  logic        rst_i,
    mem_bus_if.slave    fetch_bus,
    mem_bus_if.slave    data_bus,
    input  logic [31:0] sram_rdata_i,
    input  logic        sram_data_valid_i,
    output logic [31:0] sram_addr_o,
    output logic [31:0] sram_wdata_o,
    output logic        sram_ren_o,
    output logic        sram_wen_o
);

    // master 0 is fetch, master 1 is data
    logic [1:0]  m_req;
    logic [1:0]  m_we;
    logic [31:0] m_addr [2];
    logic [31:0] m_wdata [2];
    logic [1:0]  pend_q;
    logic [1:0]  pend_we_q;
    logic [31:0] pend_addr_q [2];
    logic [31:0] pend_wdata_q [2];
    logic [1:0]  cand;
    logic        busy_q;
    logic        owner_q;
    logic        port_free;
    logic        issue;
    logic        sel;
    logic        sel_we;
    logic [31:0] sel_addr;
    logic [31:0] sel_wdata;

    assign m_req      = {data_bus.req, fetch_bus.req};
    assign m_we       = {data_bus.we, fetch_bus.we};
    assign m_addr[0]  = fetch_bus.addr;
    assign m_addr[1]  = data_bus.addr;
    assign m_wdata[0] = fetch_bus.wdata;
    assign m_wdata[1] = data_bus.wdata;

    assign cand      = m_req | pend_q;
    assign port_free = !busy_q || sram_data_valid_i;
    assign issue     = port_free && (cand != 2'b00);
    // data bus first
    assign sel       = cand[1];

    always_comb begin
        sel_we    = pend_q[sel] ? pend_we_q[sel] : m_we[sel];
        sel_addr  = pend_q[sel] ? pend_addr_q[sel] : m_addr[sel];
        sel_wdata = pend_q[sel] ? pend_wdata_q[sel] : m_wdata[sel];
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pend_q     <= 2'b00;
            busy_q     <= 1'b0;
            owner_q    <= 1'b0;
            sram_ren_o <= 1'b0;
            sram_wen_o <= 1'b0;
        end else begin
            for (int m = 0; m < 2; m++) begin
                pend_q[m] <= cand[m] && !(issue && (int'(sel) == m));
            end
            sram_ren_o <= issue && !sel_we;
            sram_wen_o <= issue && sel_we;
            if (issue) begin
                busy_q  <= 1'b1;
                owner_q <= sel;
            end else if (sram_data_valid_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int m = 0; m < 2; m++) begin
            if (m_req[m]) begin
                pend_we_q[m]    <= m_we[m];
                pend_addr_q[m]  <= m_addr[m];
                pend_wdata_q[m] <= m_wdata[m];
            end
        end
        if (issue) begin
            sram_addr_o  <= sel_addr;
            sram_wdata_o <= sel_wdata;
        end
    end

    assign fetch_bus.valid = sram_data_valid_i && !owner_q;
    assign data_bus.valid  = sram_data_valid_i && owner_q;
    assign fetch_bus.rdata = sram_rdata_i;
    assign data_bus.rdata  = sram_rdata_i;

endmodule

`default_nettype wire

// ==== design/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        start_i,
    input  logic        we_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    output logic        done_o,
    output logic [31:0] rdata_o,
    mem_bus_if.master   bus
);

    logic        req_q;
    logic        busy_q;
    logic        we_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_q  <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            req_q <= start_i;
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (bus.valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            we_q    <= we_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    // load data is written back on the same edge as done
    assign done_o  = bus.valid && busy_q;
    assign rdata_o = bus.rdata;

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        take_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    output logic        instr_valid_o,
    output logic [31:0] instr_o,
    output logic [31:0] pc_o,
    mem_bus_if.master   bus
);

    logic [31:0] pc_q;
    logic        req_q;
    logic        inflight_q;
    logic        discard_q;
    logic        buf_valid_q;
    logic [31:0] buf_instr_q;
    logic [31:0] buf_pc_q;
    logic        inflight_next;
    logic        got;
    logic        buf_free;
    logic        fire;

    assign inflight_next = inflight_q && !bus.valid;
    // word belongs to pc_q unless a redirect overtook it
    assign got = bus.valid && !discard_q && !redirect_i;
    assign buf_free = (!buf_valid_q || take_i || redirect_i) && !got;
    assign fire = !inflight_next && buf_free;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q        <= RESET_PC;
            req_q       <= 1'b0;
            inflight_q  <= 1'b0;
            discard_q   <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            req_q      <= fire;
            inflight_q <= inflight_next || fire;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (got) begin
                pc_q <= pc_q + 32'd4;
            end
            // stale word still on its way back
            if (redirect_i && inflight_next) begin
                discard_q <= 1'b1;
            end else if (bus.valid) begin
                discard_q <= 1'b0;
            end
            if (got) begin
                buf_valid_q <= 1'b1;
            end else if (take_i || redirect_i) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (got) begin
            buf_instr_q <= bus.rdata;
            buf_pc_q    <= pc_q;
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = 1'b0;
    assign bus.addr  = pc_q;
    assign bus.wdata = 32'h0;

    assign instr_valid_o = buf_valid_q;
    assign instr_o       = buf_instr_q;
    assign pc_o          = buf_pc_q;

endmodule

`default_nettype wire

// ==== design/mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        valid;

    modport master (
        output req, we, addr, wdata,
        input  rdata, valid
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, valid
    );

endinterface

`default_nettype wire

// ==== design/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int XLEN = 32;

    // base opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASSB
    } alu_op_e;

    // one instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } instr_u;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire
